/* Makefile */
# AES-128 iterative core, Verilator flow

TOP := aesEncTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

# the binary exits non-zero when the testbench stops with $$fatal
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* dv/aesRefModel.svh */
/*
 AES-128 reference encryption for the testbench
 plain GF(2^8) arithmetic modulo 0x11B, S-box by inverse search
*/

`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// --------------------------------------------------
// field arithmetic
// --------------------------------------------------

// shift-and-add multiply, reduce by 0x11B
function automatic logic [7:0] refGfMul(input logic [7:0] a, input logic [7:0] b);
   logic [7:0] p;
   logic [7:0] aa;
   p  = 8'h00;
   aa = a;
   for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
         p = p ^ aa;
      end
      aa = aa[7] ? ((aa << 1) ^ 8'h1B) : (aa << 1);
   end
   return p;
endfunction

// inverse by search, 0 maps to 0, then the affine map
function automatic logic [7:0] refSbox(input logic [7:0] a);
   logic [7:0] inv;
   inv = 8'h00;
   for (int b = 1; b < 256; b++) begin
      if (refGfMul(a, b[7:0]) == 8'h01) begin
         inv = b[7:0];
      end
   end
   return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
        ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// --------------------------------------------------
// full encryption
// --------------------------------------------------

// byte 4*c+r is row r of column c, byte 0 on top
function automatic aesBlock aesRefEncrypt(input aesBlock key, input aesBlock pt);
   logic [7:0] s [0:15];
   logic [7:0] t [0:15];
   logic [7:0] k [0:15];
   logic [7:0] w [0:3];
   logic [7:0] rc;
   aesBlock    ct;
   rc = 8'h01;
   for (int i = 0; i < 16; i++) begin
      k[i] = key[127 - 8*i -: 8];
      s[i] = pt[127 - 8*i -: 8] ^ k[i];
   end
   for (int rnd = 1; rnd <= aesNumRounds; rnd++) begin
      // RotWord, SubWord, Rcon on the last key word
      w[0] = refSbox(k[13]) ^ rc;
      w[1] = refSbox(k[14]);
      w[2] = refSbox(k[15]);
      w[3] = refSbox(k[12]);
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            k[4*c + r] = k[4*c + r] ^ ((c == 0) ? w[r] : k[4*(c - 1) + r]);
         end
      end
      rc = refGfMul(rc, 8'h02);
      // SubBytes with ShiftRows
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            t[4*c + r] = refSbox(s[4*((c + r) % 4) + r]);
         end
      end
      for (int c = 0; c < 4; c++) begin
         if (rnd < aesNumRounds) begin
            s[4*c]     = refGfMul(t[4*c], 8'h02) ^ refGfMul(t[4*c+1], 8'h03)
                       ^ t[4*c+2] ^ t[4*c+3];
            s[4*c + 1] = t[4*c] ^ refGfMul(t[4*c+1], 8'h02)
                       ^ refGfMul(t[4*c+2], 8'h03) ^ t[4*c+3];
            s[4*c + 2] = t[4*c] ^ t[4*c+1] ^ refGfMul(t[4*c+2], 8'h02)
                       ^ refGfMul(t[4*c+3], 8'h03);
            s[4*c + 3] = refGfMul(t[4*c], 8'h03) ^ t[4*c+1] ^ t[4*c+2]
                       ^ refGfMul(t[4*c+3], 8'h02);
         end else begin
            for (int r = 0; r < 4; r++) begin
               s[4*c + r] = t[4*c + r];
            end
         end
      end
      for (int i = 0; i < 16; i++) begin
         s[i] = s[i] ^ k[i];
      end
   end
   for (int i = 0; i < 16; i++) begin
      ct[127 - 8*i -: 8] = s[i];
   end
   return ct;
endfunction

`endif

/* dv/aesEncTb.sv */
/*
 testbench for the AES-128 iterative core
 FIPS vector, random keys and blocks, busy and enable behavior
*/

`timescale 1ns/1ps

module aesEncTb;
   import aesPkg::*;

   `include "aesRefModel.svh"

   // --------------------------------------------------
   // run limits
   // --------------------------------------------------

   // blocks per test 1 + 3 + 20 + 2 + 2
   localparam int numBlocks     = 28;
   localparam int slackCycles   = 200;
   localparam int timeoutCycles = numBlocks * (aesNumRounds + 4) + slackCycles;

   localparam aesBlock fipsKey = 128'h000102030405060708090a0b0c0d0e0f;
   localparam aesBlock fipsPt  = 128'h00112233445566778899aabbccddeeff;
   localparam aesBlock fipsCt  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

   logic    CLK;
   logic    rst;
   logic    EN;
   aesBlock Kin;
   logic    Krdy;
   aesBlock Din;
   logic    Drdy;
   aesBlock Dout;
   logic    Kvld;
   logic    Dvld;
   logic    BSY;

   // expected ciphertexts in order
   aesBlock expQ [$];
   aesBlock curKey;
   int      kvldCount;
   int      dvldCount;
   int      cycleCnt;

   aesEnc u_aesEnc (
      .CLK (CLK),
      .rst (rst),
      .EN  (EN),
      .Kin (Kin),
      .Krdy(Krdy),
      .Din (Din),
      .Drdy(Drdy),
      .Dout(Dout),
      .Kvld(Kvld),
      .Dvld(Dvld),
      .BSY (BSY)
   );

   always #20 CLK = ~CLK;

   // --------------------------------------------------
   // checks
   // --------------------------------------------------

   task automatic reportFail(input string what);
      $display("%s", what);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic checkBlock(input string name, input aesBlock expVal, input aesBlock actVal);
      if (actVal !== expVal) begin
         $display("ERR %s expected %h actual %h", name, expVal, actVal);
         reportFail("block value mismatch");
      end
   endtask

   task automatic checkBit(input string name, input logic expVal, input logic actVal);
      if (actVal !== expVal) begin
         $display("ERR %s expected %h actual %h", name, expVal, actVal);
         reportFail("control bit mismatch");
      end
   endtask

   // latencies and pulse counts
   task automatic checkCount(input string name, input int expVal, input int actVal);
      if (actVal != expVal) begin
         $display("ERR %s expected %h actual %h", name, expVal, actVal);
         reportFail("cycle or pulse count mismatch");
      end
   endtask

   function automatic aesBlock randBlock();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   // --------------------------------------------------
   // stimulus tasks driving on the falling edge
   // --------------------------------------------------

   // Kvld must be high for one cycle only
   task automatic loadKey(input aesBlock key);
      @(negedge CLK);
      Kin  = key;
      Krdy = 1'b1;
      @(negedge CLK);
      Krdy = 1'b0;
      checkBit("Kvld", 1'b1, Kvld);
      @(negedge CLK);
      checkBit("Kvld", 1'b0, Kvld);
      curKey = key;
   endtask

   // lat counts cycles from the accepting edge to Dvld
   // optional EN freeze and handshake poke while busy
   task automatic encryptBlock(input aesBlock pt, input aesBlock expCt,
                               input int freezeAt, input int freezeLen,
                               input int pokeAt, output int lat);
      expQ.push_back(expCt);
      @(negedge CLK);
      Din  = pt;
      Drdy = 1'b1;
      @(negedge CLK);
      Drdy = 1'b0;
      lat  = 0;
      while (!Dvld) begin
         if (lat == freezeAt) begin
            EN = 1'b0;
         end
         if (freezeAt > 0 && lat == freezeAt + freezeLen) begin
            EN = 1'b1;
         end
         // core should ignore this junk key and block
         if (lat == pokeAt) begin
            Kin  = ~curKey;
            Krdy = 1'b1;
            Din  = ~pt;
            Drdy = 1'b1;
         end
         if (pokeAt > 0 && lat == pokeAt + 2) begin
            Krdy = 1'b0;
            Drdy = 1'b0;
         end
         @(negedge CLK);
         lat++;
      end
   endtask

   // --------------------------------------------------
   // monitors
   // --------------------------------------------------

   // values seen here are the ones before this edge
   always @(posedge CLK) begin : compareProc
      aesBlock expBlock;
      if (!rst && EN && Kvld) begin
         kvldCount++;
      end
      if (!rst && EN && Dvld) begin
         dvldCount++;
         if (expQ.size() == 0) begin
            reportFail("Dvld pulsed with no block in flight");
         end else begin
            expBlock = expQ.pop_front();
            checkBlock("Dout", expBlock, Dout);
         end
      end
   end

   always @(posedge CLK) begin
      cycleCnt++;
      if (cycleCnt >= timeoutCycles) begin
         reportFail("run timed out before all tests finished");
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial begin
      aesBlock pt;
      aesBlock expCt;
      int      lat;
      int      k;
      int      kvldBefore;
      CLK       = 1'b0;
      rst       = 1'b1;
      EN        = 1'b0;
      Kin       = '0;
      Krdy      = 1'b0;
      Din       = '0;
      Drdy      = 1'b0;
      curKey    = '0;
      kvldCount = 0;
      dvldCount = 0;
      cycleCnt  = 0;
      void'($urandom(41332));
      repeat (8) @(negedge CLK);
      rst = 1'b0;
      EN  = 1'b1;

      // FIPS-197 appendix vector checked against the model first
      checkBlock("aesRefEncrypt", fipsCt, aesRefEncrypt(fipsKey, fipsPt));
      loadKey(fipsKey);
      encryptBlock(fipsPt, fipsCt, -1, 0, -1, lat);
      checkCount("Dvld latency", aesNumRounds, lat);

      // one key for three blocks
      kvldBefore = kvldCount;
      loadKey(randBlock());
      repeat (3) @(negedge CLK);
      checkCount("Kvld pulses", kvldBefore + 1, kvldCount);
      for (int i = 0; i < 3; i++) begin
         pt = randBlock();
         encryptBlock(pt, aesRefEncrypt(curKey, pt), -1, 0, -1, lat);
      end

      // new key before every block
      for (int i = 0; i < 20; i++) begin
         loadKey(randBlock());
         pt = randBlock();
         encryptBlock(pt, aesRefEncrypt(curKey, pt), -1, 0, -1, lat);
      end

      // Krdy and Drdy while busy
      repeat (2) @(negedge CLK);
      kvldBefore = kvldCount;
      pt = randBlock();
      encryptBlock(pt, aesRefEncrypt(curKey, pt), -1, 0, 4, lat);
      checkCount("Dvld latency", aesNumRounds, lat);
      // master key must be untouched
      pt = randBlock();
      encryptBlock(pt, aesRefEncrypt(curKey, pt), -1, 0, -1, lat);
      repeat (2) @(negedge CLK);
      checkCount("Kvld pulses", kvldBefore, kvldCount);

      // EN low for k cycles mid-block
      for (int i = 0; i < 2; i++) begin
         k     = 1 + int'($urandom() % 8);
         pt    = randBlock();
         expCt = aesRefEncrypt(curKey, pt);
         encryptBlock(pt, expCt, 1 + int'($urandom() % 8), k, -1, lat);
         checkCount("Dvld latency", aesNumRounds + k, lat);
      end

      // frozen valid stays high and Dout then holds
      EN = 1'b0;
      repeat (3) begin
         @(negedge CLK);
         checkBit("Dvld", 1'b1, Dvld);
      end
      EN = 1'b1;
      @(negedge CLK);
      checkBit("Dvld", 1'b0, Dvld);
      repeat (5) @(negedge CLK);
      checkBlock("Dout", expCt, Dout);
      checkBit("BSY", 1'b0, BSY);

      repeat (4) @(negedge CLK);
      if (expQ.size() != 0 || dvldCount != numBlocks) begin
         $display("ERR Dvld count expected %h actual %h", numBlocks, dvldCount);
         reportFail("blocks left without a result");
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

/* project.f */
+incdir+dv
src/gfPkg.sv
src/aesPkg.sv
src/sboxComposite.sv
src/aesKeySched.sv
src/aesRound.sv
src/aesEnc.sv
dv/aesEncTb.sv

/* src/aesEnc.sv */
/*
 AES-128 encryption core, one round per enabled clock
 key and data load handshakes, busy flag, output valid pulse
 EN low freezes every register
*/

`timescale 1ns/1ps

module aesEnc (
   input  logic            CLK,
   input  logic            rst,
   input  logic            EN,
   input  aesPkg::aesBlock Kin,
   input  logic            Krdy,
   input  aesPkg::aesBlock Din,
   input  logic            Drdy,
   output aesPkg::aesBlock Dout,
   output logic            Kvld,
   output logic            Dvld,
   output logic            BSY
);
   import aesPkg::*;

   // --------------------------------------------------
   // registers and round wiring
   // --------------------------------------------------

   aesBlock              masterKey;
   aesState              state;
   // key of the previous round
   aesBlock              roundKey;
   aesByte               rcon;
   // round about to run, 0 when idle
   logic [aesCntW-1:0]   roundCnt;

   // combinational next values
   aesBlock              nextKey;
   aesState              roundOut;

   logic                 finalRound;
   logic                 blockDone;
   // handshakes only honoured when idle
   logic                 keyAccept;
   logic                 dataAccept;

   assign keyAccept  = Krdy & ~BSY;
   assign dataAccept = Drdy & ~BSY;

   // counter decode
   assign finalRound = (roundCnt == aesCntW'(aesNumRounds));
   assign blockDone  = BSY & finalRound;

   // key for this round comes straight from the schedule
   aesKeySched u_keySched (
      .roundKey(roundKey),
      .rcon    (rcon),
      .nextKey (nextKey)
   );

   aesRound u_round (
      .stateIn   (state),
      .roundKey  (nextKey),
      .finalRound(finalRound),
      .stateOut  (roundOut)
   );

   // --------------------------------------------------
   // key load
   // --------------------------------------------------

   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         masterKey <= '0;
         Kvld      <= 1'b0;
      end else if (EN) begin
         if (keyAccept) begin
            masterKey <= Kin;
         end
         // one-cycle ack of the load
         Kvld <= keyAccept;
      end
   end

   // --------------------------------------------------
   // round control
   // --------------------------------------------------

   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         BSY      <= 1'b0;
         Dvld     <= 1'b0;
         roundCnt <= '0;
      end else if (EN) begin
         if (dataAccept) begin
            BSY      <= 1'b1;
            roundCnt <= aesCntW'(1);
         end else if (blockDone) begin
            BSY      <= 1'b0;
            roundCnt <= '0;
         end else if (BSY) begin
            roundCnt <= roundCnt + 1'b1;
         end
         Dvld <= blockDone;
      end
   end

   // --------------------------------------------------
   // datapath
   // --------------------------------------------------

   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         state    <= '0;
         roundKey <= '0;
         rcon     <= '0;
         Dout     <= '0;
      end else if (EN) begin
         if (dataAccept) begin
            // initial AddRoundKey
            state    <= Din ^ masterKey;
            roundKey <= masterKey;
            rcon     <= aesRconInit;
         end else if (BSY) begin
            state    <= roundOut;
            roundKey <= nextKey;
            rcon     <= aesXtime(rcon);
         end
         // Dout holds until the next block finishes
         if (blockDone) begin
            Dout <= roundOut;
         end
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------

   // counter wraps to 0 after the last round
   assert property (@(posedge CLK) disable iff (rst)
      roundCnt <= aesCntW'(aesNumRounds));

   // valid pulse spans a single enabled cycle
   assert property (@(posedge CLK) disable iff (rst)
      (Dvld && EN) |=> !Dvld);

   // core goes idle with the result unless a new block is taken at once
   assert property (@(posedge CLK) disable iff (rst)
      (Dvld && EN) |=> (!BSY || $past(Drdy)));

endmodule

/* src/aesKeySched.sv */
/*
 AES-128 key schedule step
 derives the next round key from the current one and Rcon
*/

`timescale 1ns/1ps

module aesKeySched (
   input  aesPkg::aesBlock roundKey,
   input  aesPkg::aesByte  rcon,
   output aesPkg::aesBlock nextKey
);

   // --------------------------------------------------
   // RotWord and SubWord on the last key word
   // --------------------------------------------------

   // last word w3 is roundKey[31:0]
   logic [31:0] rotWord;
   logic [31:0] subWord;
   // after Rcon
   logic [31:0] tempWord;

   // output words, w0 at the top
   logic [31:0] w0, w1, w2, w3;

   // rotate one byte left
   assign rotWord = {roundKey[23:0], roundKey[31:24]};

   genvar i;
   generate
      for (i = 0; i < 4; i++) begin : gSub
         sboxComposite u_sbox (
            .x(rotWord[8*i +: 8]),
            .y(subWord[8*i +: 8])
         );
      end
   endgenerate

   // Rcon only touches the top byte
   assign tempWord = {subWord[31:24] ^ rcon, subWord[23:0]};

   // --------------------------------------------------
   // word chain
   // --------------------------------------------------

   // each word depends on the one before it
   assign w0 = tempWord ^ roundKey[127:96];
   assign w1 = w0 ^ roundKey[95:64];
   assign w2 = w1 ^ roundKey[63:32];
   assign w3 = w2 ^ roundKey[31:0];

   assign nextKey = {w0, w1, w2, w3};

endmodule

/* src/aesPkg.sv */
/*
 AES-128 types and constants
 block, byte, state views, round count, key-schedule constants
*/

package aesPkg;

   // --------------------------------------------------
   // basic types
   // --------------------------------------------------

   // one GF(2^8) element
   typedef logic [7:0]   aesByte;

   // key, plaintext or ciphertext
   typedef logic [127:0] aesBlock;

   // state seen two ways
   // bytes[0] is the most significant byte, column-major order
   // cols[0] holds bytes 0..3
   typedef union packed {
      aesByte [0:15]        bytes;
      logic   [0:3][31:0]   cols;
   } aesState;

   // --------------------------------------------------
   // constants
   // --------------------------------------------------

   localparam int     aesNumRounds = 10;
   // wide enough to hold 0..aesNumRounds
   localparam int     aesCntW      = $clog2(aesNumRounds + 1);

   // first round constant
   localparam aesByte aesRconInit  = 8'h01;
   // x^8 = x^4 + x^3 + x + 1, low byte of 0x11B
   localparam aesByte aesRconPoly  = 8'h1B;
   // S-box affine constant
   localparam aesByte aesAffineC   = 8'h63;

   // multiply by x in GF(2^8)
   function automatic aesByte aesXtime(input aesByte a);
      return {a[6:0], 1'b0} ^ (a[7] ? aesRconPoly : 8'h00);
   endfunction

endpackage

/* src/aesRound.sv */
/*
 one AES encryption round, purely combinational
 SubBytes, ShiftRows, MixColumns, AddRoundKey
 MixColumns skipped when finalRound is set
*/

`timescale 1ns/1ps

module aesRound (
   input  aesPkg::aesState stateIn,
   input  aesPkg::aesBlock roundKey,
   input  logic            finalRound,
   output aesPkg::aesState stateOut
);
   import aesPkg::*;

   // S-box outputs, same byte order as the state
   aesByte  subOut [0:15];
   // after ShiftRows
   aesState shifted;
   // round key split into columns
   aesState rk;

   assign rk = roundKey;

   // --------------------------------------------------
   // SubBytes
   // --------------------------------------------------

   genvar i;
   generate
      for (i = 0; i < 16; i++) begin : gSub
         sboxComposite u_sbox (
            .x(stateIn.bytes[i]),
            .y(subOut[i])
         );
      end
   endgenerate

   // --------------------------------------------------
   // ShiftRows
   // --------------------------------------------------

   // byte 4*c+r is row r of column c
   // row r rotates left by r columns
   always_comb begin
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            shifted.bytes[4*c + r] = subOut[4*((c + r) % 4) + r];
         end
      end
   end

   // --------------------------------------------------
   // MixColumns and AddRoundKey
   // --------------------------------------------------

   always_comb begin
      aesByte      a0, a1, a2, a3;
      aesByte      b0, b1, b2, b3;
      logic [31:0] mixCol;
      for (int c = 0; c < 4; c++) begin
         a0 = shifted.cols[c][31:24];
         a1 = shifted.cols[c][23:16];
         a2 = shifted.cols[c][15:8];
         a3 = shifted.cols[c][7:0];
         // doubled bytes
         b0 = aesXtime(a0);
         b1 = aesXtime(a1);
         b2 = aesXtime(a2);
         b3 = aesXtime(a3);
         // 3*a is b^a
         mixCol = {b0 ^ b1 ^ a1 ^ a2 ^ a3,
                   a0 ^ b1 ^ b2 ^ a2 ^ a3,
                   a0 ^ a1 ^ b2 ^ b3 ^ a3,
                   b0 ^ a0 ^ a1 ^ a2 ^ b3};
         // last round bypasses the mix
         stateOut.cols[c] = (finalRound ? shifted.cols[c] : mixCol) ^ rk.cols[c];
      end
   end

endmodule

/* src/gfPkg.sv */
/*
 composite-field definitions for the AES S-box
 GF(2^8) is handled as GF((2^4)^2) over GF((2^2)^2)
*/

package gfPkg;

   // --------------------------------------------------
   // sub-field widths
   // --------------------------------------------------

   // one GF(2^4) element
   localparam int gfNibbleW = 4;
   // one GF(2^2) element
   localparam int gfPairW   = 2;

   // --------------------------------------------------
   // field-defining constants
   // --------------------------------------------------

   // GF((2^4)^2) built as x^2 + x + lambda over GF(2^4)
   localparam logic [gfNibbleW-1:0] gfLambda = 4'b1100;

   // GF(2^4) built as x^2 + x + phi over GF(2^2)
   localparam logic [gfPairW-1:0]   gfPhi    = 2'b10;

   // GF(2^2) itself uses x^2 + x + 1
   // the isomorphism matrices in the S-box match these choices

endpackage

/* src/sboxComposite.sv */
/*
 AES S-box, one byte, purely combinational
 inverse taken in GF((2^4)^2), then affine map with 0x63
*/

`timescale 1ns/1ps

module sboxComposite (
   input  aesPkg::aesByte x,
   output aesPkg::aesByte y
);
   import gfPkg::*;
   import aesPkg::*;

   // mapped input and inverted result, composite basis
   aesByte xt;
   aesByte yt;

   // GF(2^4) halves
   logic [gfNibbleW-1:0] g1, g0, g1g0;
   logic [gfNibbleW-1:0] p, pInv;

   // GF(2^2) halves of p
   logic [gfPairW-1:0] h1, h0, h1h0;
   logic [gfPairW-1:0] q, qInv;

   // --------------------------------------------------
   // basis changes
   // --------------------------------------------------

   // GF(2^8) -> GF((2^4)^2)
   function automatic aesByte matX(input aesByte a);
      aesByte r;
      r[7] = a[7] ^ a[5];
      r[6] = a[7] ^ a[6] ^ a[4] ^ a[3] ^ a[2] ^ a[1];
      r[5] = a[7] ^ a[5] ^ a[3] ^ a[2];
      r[4] = a[7] ^ a[5] ^ a[3] ^ a[2] ^ a[1];
      r[3] = a[7] ^ a[6] ^ a[2] ^ a[1];
      r[2] = a[7] ^ a[4] ^ a[3] ^ a[2] ^ a[1];
      r[1] = a[6] ^ a[4] ^ a[1];
      r[0] = a[6] ^ a[1] ^ a[0];
      return r;
   endfunction

   // GF((2^4)^2) -> GF(2^8)
   function automatic aesByte matXi(input aesByte a);
      aesByte r;
      r[7] = a[7] ^ a[6] ^ a[5] ^ a[1];
      r[6] = a[6] ^ a[2];
      r[5] = a[6] ^ a[5] ^ a[1];
      r[4] = a[6] ^ a[5] ^ a[4] ^ a[2] ^ a[1];
      r[3] = a[5] ^ a[4] ^ a[3] ^ a[2] ^ a[1];
      r[2] = a[7] ^ a[4] ^ a[3] ^ a[2] ^ a[1];
      r[1] = a[5] ^ a[4];
      r[0] = a[6] ^ a[5] ^ a[4] ^ a[2] ^ a[0];
      return r;
   endfunction

   // affine matrix only, constant added at the output
   function automatic aesByte affine(input aesByte a);
      aesByte r;
      for (int i = 0; i < 8; i++) begin
         r[i] = a[i] ^ a[(i + 4) % 8] ^ a[(i + 5) % 8] ^ a[(i + 6) % 8] ^ a[(i + 7) % 8];
      end
      return r;
   endfunction

   // --------------------------------------------------
   // GF(2^4) arithmetic
   // --------------------------------------------------

   function automatic logic [gfNibbleW-1:0] gfSq4(input logic [gfNibbleW-1:0] a);
      return {a[3], a[3] ^ a[2], a[2] ^ a[1], a[3] ^ a[1] ^ a[0]};
   endfunction

   function automatic logic [gfNibbleW-1:0] gfMul4(input logic [gfNibbleW-1:0] a,
                                                   input logic [gfNibbleW-1:0] b);
      logic [gfNibbleW-1:0] r;
      r[3] = a[3]&b[3] ^ a[3]&b[1] ^ a[1]&b[3] ^ a[2]&b[3] ^ a[2]&b[1]
           ^ a[0]&b[3] ^ a[3]&b[2] ^ a[3]&b[0] ^ a[1]&b[2];
      r[2] = a[3]&b[3] ^ a[3]&b[1] ^ a[1]&b[3] ^ a[2]&b[2] ^ a[2]&b[0] ^ a[0]&b[2];
      r[1] = a[2]&b[3] ^ a[3]&b[2] ^ a[2]&b[2] ^ a[1]&b[1] ^ a[0]&b[1] ^ a[1]&b[0];
      r[0] = a[3]&b[3] ^ a[2]&b[3] ^ a[3]&b[2] ^ a[1]&b[1] ^ a[0]&b[0];
      return r;
   endfunction

   // --------------------------------------------------
   // GF(2^2) arithmetic
   // --------------------------------------------------

   // squaring is also the inverse here, since a^3 = 1
   function automatic logic [gfPairW-1:0] gfSq2(input logic [gfPairW-1:0] a);
      return {a[1], a[1] ^ a[0]};
   endfunction

   function automatic logic [gfPairW-1:0] gfMul2(input logic [gfPairW-1:0] a,
                                                 input logic [gfPairW-1:0] b);
      return {a[1]&b[1] ^ a[0]&b[1] ^ a[1]&b[0], a[1]&b[1] ^ a[0]&b[0]};
   endfunction

   // --------------------------------------------------
   // inversion datapath
   // --------------------------------------------------

   assign xt   = matX(x);
   assign g1   = xt[2*gfNibbleW-1:gfNibbleW];
   assign g0   = xt[gfNibbleW-1:0];
   assign g1g0 = g1 ^ g0;

   // norm: lambda*g1^2 + (g1+g0)*g0
   // lambda scaling folds to a few XORs
   assign p = gfMul4(gfSq4(g1), gfLambda) ^ gfMul4(g1g0, g0);

   // GF(2^4) inverse of p, same structure one level down
   assign h1   = p[gfNibbleW-1:gfPairW];
   assign h0   = p[gfPairW-1:0];
   assign h1h0 = h1 ^ h0;
   assign q    = gfMul2(gfSq2(h1), gfPhi) ^ gfMul2(h1h0, h0);
   assign qInv = gfSq2(q);
   assign pInv = {gfMul2(h1, qInv), gfMul2(h1h0, qInv)};

   // scale both halves by the inverted norm
   assign yt = {gfMul4(g1, pInv), gfMul4(g1g0, pInv)};

   // back to the AES basis, then affine
   assign y = affine(matXi(yt)) ^ aesAffineC;

endmodule
